// File: motion_pkg.sv
package motion_pkg;

  // Move memory geometry
  localparam int MOVE_DEPTH = 8;   // Entries held
  localparam int MOVE_PTR_W = 3;   // Pointer bits, depth is a power of two

  // Level value when every entry is taken
  localparam logic [MOVE_PTR_W:0] LEVEL_FULL = (MOVE_PTR_W + 1)'(MOVE_DEPTH);

  // DDA tick divider
  localparam int DIV_W = 8;                              // Divisor width
  localparam logic [DIV_W-1:0] DIVISOR_RESET = 8'd3;     // Tick every 4 cycles

  // One queued motion segment
  typedef struct packed {
    logic               dir;        // 1 counts position up
    logic [31:0]        duration;   // Move lasts duration+1 ticks
    logic signed [31:0] increment;  // Starting rate
    logic signed [31:0] accel;      // Rate change per tick
  } move_t;

  // Fill state of the move store, shared by both peers
  typedef struct packed {
    logic [MOVE_PTR_W:0] level;  // Entries held
    logic                full;
    logic                empty;
  } store_status_t;

endpackage

// File: apb_regs_pkg.sv
package apb_regs_pkg;

  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  // Host to slave
  typedef struct packed {
    logic [APB_ADDR_W-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_DATA_W-1:0] pwdata;
  } apb_req_t;

  // Slave to host
  typedef struct packed {
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;  // Only meaningful with pready
  } apb_rsp_t;

  // Register map
  localparam logic [APB_ADDR_W-1:0] REG_CTRL      = 8'h00;  // bit0 enable, bit1 halt
  localparam logic [APB_ADDR_W-1:0] REG_DIVISOR   = 8'h04;
  localparam logic [APB_ADDR_W-1:0] REG_DURATION  = 8'h08;
  localparam logic [APB_ADDR_W-1:0] REG_INCREMENT = 8'h0C;
  localparam logic [APB_ADDR_W-1:0] REG_ACCEL     = 8'h10;
  localparam logic [APB_ADDR_W-1:0] REG_COMMIT    = 8'h14;  // Write only, bit0 dir
  localparam logic [APB_ADDR_W-1:0] REG_STATUS    = 8'h18;
  localparam logic [APB_ADDR_W-1:0] REG_POSITION  = 8'h1C;
  localparam logic [APB_ADDR_W-1:0] REG_ENCODER   = 8'h20;
  localparam logic [APB_ADDR_W-1:0] REG_VERSION   = 8'h24;

  localparam logic [7:0] VERSION_MAJOR = 8'd1;
  localparam logic [7:0] VERSION_MINOR = 8'd2;
  localparam logic [7:0] VERSION_PATCH = 8'd0;

endpackage

// File: apb_cmd_regs.sv
`timescale 1ns/1ps

module apb_cmd_regs import motion_pkg::*, apb_regs_pkg::*; (
  input  logic               CLK,
  input  logic               resetn,
  input  apb_req_t           apb_req,
  input  logic               wr_gnt,     // Store accepted the commit
  input  store_status_t      status,
  input  logic               busy,       // Step engine running a move
  input  logic signed [31:0] position,
  input  logic signed [31:0] enc_count,
  input  logic               enc_fault,
  output apb_rsp_t           apb_rsp,
  output logic               wr_req,
  output move_t              wr_move,
  output logic               flush,      // One cycle, empties the store
  output logic               enable,
  output logic [DIV_W-1:0]   divisor
);

  logic               ctrl_halt;        // Last halt bit written
  logic [31:0]        stage_duration;   // Staged fields for the next commit
  logic signed [31:0] stage_increment;
  logic signed [31:0] stage_accel;
  logic               access;           // APB access phase
  logic               wr_access;
  logic               commit_access;
  logic               addr_ok;          // Offset decodes to a register
  logic [31:0]        rdata;

  assign access        = apb_req.psel & apb_req.penable;
  assign wr_access     = access & apb_req.pwrite;
  assign commit_access = wr_access & (apb_req.paddr == REG_COMMIT);

  // Request held through the access phase until granted
  // Never raised while full, that case errors out at once
  assign wr_req = commit_access & ~status.full;

  always_comb begin
    wr_move.dir       = apb_req.pwdata[0];  // Direction comes with the commit
    wr_move.duration  = stage_duration;
    wr_move.increment = stage_increment;
    wr_move.accel     = stage_accel;
  end

  // Halt write flushes the store during the access cycle
  assign flush = wr_access & (apb_req.paddr == REG_CTRL) & apb_req.pwdata[1];

  // Control registers
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      enable    <= 1'b0;
      ctrl_halt <= 1'b0;
      divisor   <= DIVISOR_RESET;
    end else if (wr_access) begin
      case (apb_req.paddr)
        REG_CTRL: begin
          enable    <= apb_req.pwdata[0];
          ctrl_halt <= apb_req.pwdata[1];
        end
        REG_DIVISOR: divisor <= apb_req.pwdata[DIV_W-1:0];
        default: ;  // Read-only and commit offsets
      endcase
    end
  end

  // Move staging, plain data
  always_ff @(posedge CLK) begin
    if (wr_access) begin
      case (apb_req.paddr)
        REG_DURATION:  stage_duration  <= apb_req.pwdata;
        REG_INCREMENT: stage_increment <= apb_req.pwdata;
        REG_ACCEL:     stage_accel     <= apb_req.pwdata;
        default: ;
      endcase
    end
  end

  // Read mux and address decode
  always_comb begin
    addr_ok = 1'b1;
    rdata   = '0;
    case (apb_req.paddr)
      REG_CTRL:      rdata = {30'b0, ctrl_halt, enable};
      REG_DIVISOR:   rdata = {{(32 - DIV_W){1'b0}}, divisor};
      REG_DURATION:  rdata = stage_duration;
      REG_INCREMENT: rdata = stage_increment;
      REG_ACCEL:     rdata = stage_accel;
      REG_COMMIT:    rdata = '0;               // Write only, reads as zero
      REG_STATUS:    rdata = {20'b0, status.level, 4'b0,
                              enc_fault, busy, status.empty, status.full};
      REG_POSITION:  rdata = position;
      REG_ENCODER:   rdata = enc_count;
      REG_VERSION:   rdata = {8'h00, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH};
      default:       addr_ok = 1'b0;           // Unmapped
    endcase
  end

  // Zero wait states except a commit waiting on the arbiter
  always_comb begin
    apb_rsp.prdata  = rdata;
    apb_rsp.pready  = commit_access ? (status.full | wr_gnt) : 1'b1;
    apb_rsp.pslverr = access & (~addr_ok | (commit_access & status.full));
  end

endmodule

// File: move_store.sv
`timescale 1ns/1ps

module move_store import motion_pkg::*; (
  input  logic          CLK,
  input  logic          resetn,
  input  logic          flush,    // Drop every queued move
  input  logic          wr_req,   // Commit writer
  input  move_t         wr_move,
  input  logic          rd_req,   // Step engine
  output logic          wr_gnt,
  output logic          rd_gnt,
  output move_t         rd_move,  // Valid the cycle after rd_gnt
  output store_status_t status
);

  move_t                 mem [MOVE_DEPTH];  // Single port, one access per cycle
  logic [MOVE_PTR_W-1:0] wr_ptr;            // Wraps on its own
  logic [MOVE_PTR_W-1:0] rd_ptr;
  logic [MOVE_PTR_W:0]   level;

  always_comb begin
    status.level = level;
    status.full  = (level == LEVEL_FULL);
    status.empty = (level == '0);
  end

  // Reader first, writer only when the port is free
  // No access at all in a flush cycle
  assign rd_gnt = rd_req & ~status.empty & ~flush;
  assign wr_gnt = wr_req & ~status.full & ~flush & ~rd_gnt;

  // Pointers and fill level
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else if (rd_gnt) begin
      rd_ptr <= rd_ptr + 1'b1;
      level  <= level - 1'b1;
    end else if (wr_gnt) begin
      wr_ptr <= wr_ptr + 1'b1;
      level  <= level + 1'b1;
    end
  end

  // Memory port, registered read
  always_ff @(posedge CLK) begin
    if (wr_gnt) begin
      mem[wr_ptr] <= wr_move;
    end
    if (rd_gnt) begin
      rd_move <= mem[rd_ptr];
    end
  end

endmodule

// File: dda_stepper.sv
`timescale 1ns/1ps

module dda_stepper import motion_pkg::*; (
  input  logic               CLK,
  input  logic               resetn,
  input  logic               enable,    // Gates new loads only
  input  logic [DIV_W-1:0]   divisor,
  input  logic               flush,
  input  logic               rd_gnt,
  input  move_t              rd_move,
  input  store_status_t      status,
  output logic               rd_req,
  output logic               step,      // One-cycle pulse per carry
  output logic               dir,
  output logic               busy,
  output logic signed [31:0] position
);

  typedef enum logic [1:0] {
    ST_IDLE,  // Waiting for a move and enable
    ST_REQ,   // Asking the store
    ST_RUN    // Load cycle, then ticking
  } state_t;

  state_t             state;
  logic               load_q;     // rd_move valid this cycle
  logic [DIV_W-1:0]   div_cnt;    // Cycles to the next tick
  logic [31:0]        remaining;  // Ticks left after the current one
  logic signed [31:0] rate;
  logic signed [31:0] accel;
  logic [31:0]        phase;      // Kept across moves
  logic               tick;
  logic [32:0]        phase_sum;  // Bit 32 is the step carry

  assign rd_req = (state == ST_REQ);
  assign busy   = (state != ST_IDLE);

  assign tick      = (state == ST_RUN) & ~load_q & (div_cnt == '0);
  assign phase_sum = {1'b0, phase} + {1'b0, rate};  // Unsigned add of rate bits

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state     <= ST_IDLE;
      load_q    <= 1'b0;
      div_cnt   <= '0;
      remaining <= '0;
      phase     <= '0;
      step      <= 1'b0;
      dir       <= 1'b0;
      position  <= '0;
    end else begin
      step   <= 1'b0;
      load_q <= 1'b0;
      if (flush) begin
        state <= ST_IDLE;  // Abandon the move, phase and position kept
      end else begin
        case (state)
          ST_IDLE: begin
            if (enable && !status.empty) state <= ST_REQ;
          end
          ST_REQ: begin
            if (rd_gnt) begin      // Store already popped, must run it
              state  <= ST_RUN;
              load_q <= 1'b1;
            end else if (!enable) begin
              state <= ST_IDLE;
            end
          end
          ST_RUN: begin
            if (load_q) begin
              dir       <= rd_move.dir;
              remaining <= rd_move.duration;
              div_cnt   <= divisor;     // First tick divisor+1 cycles on
            end else if (tick) begin
              div_cnt <= divisor;
              phase   <= phase_sum[31:0];
              step    <= phase_sum[32];
              if (phase_sum[32]) begin
                position <= dir ? position + 1 : position - 1;
              end
              if (remaining == '0) begin
                state <= ST_IDLE;       // Last tick of the move
              end else begin
                remaining <= remaining - 1'b1;
              end
            end else begin
              div_cnt <= div_cnt - 1'b1;
            end
          end
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

  // Rate integrates accel once per tick
  always_ff @(posedge CLK) begin
    if (state == ST_RUN && load_q) begin
      rate  <= rd_move.increment;
      accel <= rd_move.accel;
    end else if (tick) begin
      rate <= rate + accel;
    end
  end

endmodule

// File: quad_encoder.sv
`timescale 1ns/1ps

module quad_encoder (
  input  logic               CLK,
  input  logic               resetn,
  input  logic               enc_a,
  input  logic               enc_b,
  output logic signed [31:0] count,   // Four counts per cycle of A
  output logic               fault    // Sticky, skipped state seen
);

  logic [1:0] sync_a;   // Two-flop synchronizers
  logic [1:0] sync_b;
  logic [1:0] ab_cur;   // {A, B} after sync
  logic [1:0] ab_prev;

  assign ab_cur = {sync_a[1], sync_b[1]};

  // Free running, settles while reset is held
  always_ff @(posedge CLK) begin
    sync_a  <= {sync_a[0], enc_a};
    sync_b  <= {sync_b[0], enc_b};
    ab_prev <= ab_cur;
  end

  // A leading B counts up: 00 10 11 01
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      count <= '0;
      fault <= 1'b0;
    end else begin
      case ({ab_prev, ab_cur})
        4'b0010, 4'b1011, 4'b1101, 4'b0100: count <= count + 1;
        4'b0001, 4'b0111, 4'b1110, 4'b1000: count <= count - 1;
        4'b0011, 4'b1100, 4'b0110, 4'b1001: fault <= 1'b1;  // Both changed
        default: ;  // No edge
      endcase
    end
  end

endmodule

// File: motion_top.sv
`timescale 1ns/1ps

module motion_top import motion_pkg::*, apb_regs_pkg::*; (
  input  logic     CLK,
  input  logic     resetn,
  input  apb_req_t apb_req,
  input  logic     enc_a,
  input  logic     enc_b,
  output apb_rsp_t apb_rsp,
  output logic     step,
  output logic     dir,
  output logic     buffer_ready   // Room for another commit
);

  logic               wr_req;
  logic               wr_gnt;
  move_t              wr_move;
  logic               rd_req;
  logic               rd_gnt;
  move_t              rd_move;
  store_status_t      status;
  logic               flush;
  logic               enable;
  logic [DIV_W-1:0]   divisor;
  logic               busy;
  logic signed [31:0] position;
  logic signed [31:0] enc_count;
  logic               enc_fault;

  assign buffer_ready = ~status.full;

  apb_cmd_regs u_regs (
    .CLK       (CLK),
    .resetn    (resetn),
    .apb_req   (apb_req),
    .wr_gnt    (wr_gnt),
    .status    (status),
    .busy      (busy),
    .position  (position),
    .enc_count (enc_count),
    .enc_fault (enc_fault),
    .apb_rsp   (apb_rsp),
    .wr_req    (wr_req),
    .wr_move   (wr_move),
    .flush     (flush),
    .enable    (enable),
    .divisor   (divisor)
  );

  // Shared move memory, engine reads take priority
  move_store u_store (
    .CLK     (CLK),
    .resetn  (resetn),
    .flush   (flush),
    .wr_req  (wr_req),
    .wr_move (wr_move),
    .rd_req  (rd_req),
    .wr_gnt  (wr_gnt),
    .rd_gnt  (rd_gnt),
    .rd_move (rd_move),
    .status  (status)
  );

  dda_stepper u_dda (
    .CLK      (CLK),
    .resetn   (resetn),
    .enable   (enable),
    .divisor  (divisor),
    .flush    (flush),
    .rd_gnt   (rd_gnt),
    .rd_move  (rd_move),
    .status   (status),
    .rd_req   (rd_req),
    .step     (step),
    .dir      (dir),
    .busy     (busy),
    .position (position)
  );

  quad_encoder u_enc (
    .CLK    (CLK),
    .resetn (resetn),
    .enc_a  (enc_a),
    .enc_b  (enc_b),
    .count  (enc_count),
    .fault  (enc_fault)
  );

endmodule

// File: tb_motion_properties.sv
`timescale 1ns/1ps

module tb_motion_properties import motion_pkg::*, apb_regs_pkg::*; (
  input logic             CLK,
  input logic             resetn,
  input apb_req_t         apb_req,
  input apb_rsp_t         apb_rsp,
  input logic             step,
  input logic             dir,
  input logic [DIV_W-1:0] divisor
);

  // Cleared by the first reset edge
  step_low_in_reset: assert property (@(posedge CLK) !resetn |=> !step)
    else $error("step high while reset is held");

  // Error only with a completing access
  slverr_in_access: assert property (@(posedge CLK) disable iff (!resetn)
    apb_rsp.pslverr |-> apb_rsp.pready && apb_req.psel && apb_req.penable)
    else $error("pslverr outside a completing access phase");

  // Ticks are spaced at least two cycles apart
  step_single_cycle: assert property (@(posedge CLK) disable iff (!resetn)
    (step && divisor != '0) |=> !step)
    else $error("step high for two cycles in a row");

  dir_stable_on_step: assert property (@(posedge CLK) disable iff (!resetn)
    step |-> $stable(dir))
    else $error("dir changed together with a step pulse");

endmodule

// File: tb_motion_top.sv
`timescale 1ns/1ps

module tb_motion_top import motion_pkg::*, apb_regs_pkg::*; ();

  localparam int APB_WAIT_MAX  = 16;    // Commit waits at most two cycles
  localparam int IDLE_POLL_MAX = 4000;  // STATUS polls per drain

  typedef struct packed {
    logic [31:0] steps;
    logic [31:0] phase;
  } dda_result_t;

  logic     CLK = 1'b0;
  logic     resetn;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  logic     enc_a;
  logic     enc_b;
  logic     step;
  logic     dir;
  logic     buffer_ready;

  logic [31:0]        lfsr = 32'h2758;
  int                 value_errors = 0;
  int                 timeout_errors = 0;
  logic [31:0]        up_cnt = '0;   // Pulses seen with dir high
  logic [31:0]        dn_cnt = '0;
  logic [31:0]        exp_up = '0;   // Model totals
  logic [31:0]        exp_dn = '0;
  logic [31:0]        tb_phase = '0; // Model copy of the DDA phase
  logic signed [31:0] exp_pos = '0;

  always #20 CLK = ~CLK;  // 40 ns period

  motion_top UUT (
    .CLK          (CLK),
    .resetn       (resetn),
    .apb_req      (apb_req),
    .enc_a        (enc_a),
    .enc_b        (enc_b),
    .apb_rsp      (apb_rsp),
    .step         (step),
    .dir          (dir),
    .buffer_ready (buffer_ready)
  );

  bind motion_top tb_motion_properties u_props (
    .CLK     (CLK),
    .resetn  (resetn),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .step    (step),
    .dir     (dir),
    .divisor (divisor)   // Internal divisor of motion_top
  );

  // Step pulses counted by the dir sampled with them
  always @(negedge CLK) begin
    if (resetn && step) begin
      if (dir) up_cnt <= up_cnt + 1;
      else dn_cnt <= dn_cnt + 1;
    end
  end

  // Galois LFSR on x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h80200003;
    return s >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};  // One LFSR step per bit
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // Each tick adds rate to phase with the carry as step and then adds accel to rate
  function automatic dda_result_t dda_model(input logic [31:0] phase_in, input move_t mv);
    dda_result_t res;
    logic [32:0] sum;
    logic [31:0] rate;
    res.steps = '0;
    res.phase = phase_in;
    rate      = mv.increment;
    for (int unsigned t = 0; t <= mv.duration; t++) begin  // duration+1 ticks
      sum       = {1'b0, res.phase} + {1'b0, rate};
      res.phase = sum[31:0];
      if (sum[32]) res.steps = res.steps + 1;
      rate = rate + mv.accel;
    end
    return res;
  endfunction

  // {A, B} for a position in the cycle with A leading B going up
  function automatic logic [1:0] quad_state(input logic [1:0] idx);
    case (idx)
      2'd0:    return 2'b00;
      2'd1:    return 2'b10;
      2'd2:    return 2'b11;
      default: return 2'b01;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      value_errors++;
      $display("error: %s is %h, expected %h", name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timeout_errors++;
    $display("timeout while waiting for %s", what);
  endtask

  task automatic finish_run();
    $display("error count: %0d wrong values, %0d timeouts", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  // One APB transfer with setup and then access until pready
  task automatic apb_access(input logic [7:0] addr, input logic write,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waits;
    waits = 0;
    @(negedge CLK);
    apb_req.paddr   = addr;
    apb_req.pwrite  = write;
    apb_req.pwdata  = wdata;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    @(negedge CLK);
    apb_req.penable = 1'b1;
    #1;  // Let the combinational response settle
    while (!apb_rsp.pready && waits < APB_WAIT_MAX) begin
      @(negedge CLK);
      #1;
      waits++;
    end
    if (!apb_rsp.pready) begin
      report_timeout("APB pready");
    end else if (!(write && addr == REG_COMMIT)) begin
      check_value("pready wait cycles", waits, 32'h0);  // Zero wait states
    end else begin
      assert (waits <= 1) else begin  // Commit held one extra cycle at most
        value_errors++;
        $display("error: pready wait cycles is %h, expected at most 1", waits);
      end
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(negedge CLK);  // Transfer done at the rising edge before
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    logic        err;
    apb_access(addr, 1'b1, data, unused, err);
    check_value("pslverr", err, 32'h0);
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
    logic err;
    apb_access(addr, 1'b0, '0, data, err);
    check_value("pslverr", err, 32'h0);
  endtask

  task automatic random_move(input logic accel_on, output move_t mv);
    logic [31:0] r;
    take_bits(5, r);
    mv.duration = r + 2;                 // 3 to 34 ticks
    take_bits(31, r);
    mv.increment = r;
    take_bits(28, r);
    mv.accel = accel_on ? {{4{r[27]}}, r[27:0]} : '0;
    take_bits(1, r);
    mv.dir = r[0];
  endtask

  task automatic commit_move(input move_t mv);
    write_reg(REG_DURATION, mv.duration);
    write_reg(REG_INCREMENT, mv.increment);
    write_reg(REG_ACCEL, mv.accel);
    write_reg(REG_COMMIT, {31'b0, mv.dir});
  endtask

  // Advance the model over one move
  task automatic run_model(input move_t mv);
    dda_result_t r;
    r        = dda_model(tb_phase, mv);
    tb_phase = r.phase;
    if (mv.dir) begin
      exp_up  = exp_up + r.steps;
      exp_pos = exp_pos + r.steps;
    end else begin
      exp_dn  = exp_dn + r.steps;
      exp_pos = exp_pos - r.steps;
    end
  endtask

  // Store empty and engine not busy
  task automatic wait_idle();
    logic [31:0] s;
    int          polls;
    polls = 0;
    read_reg(REG_STATUS, s);
    while (s[2:1] != 2'b01 && polls < IDLE_POLL_MAX) begin
      read_reg(REG_STATUS, s);
      polls++;
    end
    if (s[2:1] != 2'b01) report_timeout("engine to drain the store");
  endtask

  task automatic check_motion();
    logic [31:0] pos;
    read_reg(REG_POSITION, pos);
    check_value("position", pos, exp_pos);
    check_value("up step count", up_cnt, exp_up);
    check_value("down step count", dn_cnt, exp_dn);
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] r;
    logic        err;
    move_t       mv;
    move_t       queued [8];
    logic [1:0]  qidx;
    logic [31:0] net;
    resetn  = 1'b0;
    apb_req = '0;
    enc_a   = 1'b0;
    enc_b   = 1'b0;
    repeat (5) @(negedge CLK);
    resetn = 1'b1;

    // Reset state and register map
    check_value("step", step, 32'h0);
    check_value("dir", dir, 32'h0);
    check_value("buffer_ready", buffer_ready, 32'h1);
    check_value("pslverr", apb_rsp.pslverr, 32'h0);
    read_reg(REG_STATUS, rd);
    check_value("STATUS", rd, 32'h2);        // Empty with level 0
    read_reg(REG_VERSION, rd);
    check_value("VERSION", rd, 32'h00010200);
    read_reg(REG_POSITION, rd);
    check_value("POSITION", rd, 32'h0);
    apb_access(8'h28, 1'b0, '0, rd, err);    // Past the map
    check_value("pslverr", err, 32'h1);

    // Single constant-rate move
    random_move(1'b0, mv);
    commit_move(mv);
    run_model(mv);
    write_reg(REG_CTRL, 32'h1);
    wait_idle();
    check_motion();
    check_value("dir", dir, mv.dir);

    // Eight queued moves with acceleration
    write_reg(REG_CTRL, 32'h0);
    for (int i = 0; i < 8; i++) begin
      random_move(1'b1, queued[i]);
      commit_move(queued[i]);
    end
    read_reg(REG_STATUS, rd);
    check_value("STATUS", rd, 32'h801);      // Full with level 8
    check_value("buffer_ready", buffer_ready, 32'h0);
    apb_access(REG_COMMIT, 1'b1, 32'h1, rd, err);
    check_value("pslverr", err, 32'h1);      // No room for a ninth
    for (int i = 0; i < 8; i++) run_model(queued[i]);
    write_reg(REG_CTRL, 32'h1);
    wait_idle();
    check_motion();
    check_value("dir", dir, queued[7].dir);

    // Halt flushes queued moves before they run
    write_reg(REG_CTRL, 32'h0);
    for (int i = 0; i < 3; i++) begin
      random_move(1'b1, mv);
      commit_move(mv);
    end
    write_reg(REG_CTRL, 32'h2);
    read_reg(REG_STATUS, rd);
    check_value("STATUS", rd, 32'h2);
    write_reg(REG_CTRL, 32'h1);
    repeat (200) @(negedge CLK);             // Nothing may start
    check_motion();
    read_reg(REG_STATUS, rd);
    check_value("STATUS", rd, 32'h2);

    // Encoder walk and then a skipped state
    qidx = 2'd0;
    net  = '0;
    for (int i = 0; i < 40; i++) begin
      take_bits(1, r);
      if (r[0]) begin
        qidx = qidx + 1'b1;
        net  = net + 1;
      end else begin
        qidx = qidx - 1'b1;
        net  = net - 1;
      end
      @(negedge CLK);
      {enc_a, enc_b} = quad_state(qidx);
      repeat (4) @(negedge CLK);             // Count lands 3 cycles on
    end
    read_reg(REG_ENCODER, rd);
    check_value("ENCODER", rd, net);
    read_reg(REG_STATUS, rd);
    check_value("STATUS", rd, 32'h2);        // Fault still clear
    @(negedge CLK);
    {enc_a, enc_b} = ~{enc_a, enc_b};        // Both inputs at once
    repeat (4) @(negedge CLK);
    read_reg(REG_STATUS, rd);
    check_value("STATUS", rd, 32'hA);        // Fault bit set
    read_reg(REG_ENCODER, rd);
    check_value("ENCODER", rd, net);

    finish_run();
  end

endmodule

// File: compile.f
motion_pkg.sv
apb_regs_pkg.sv
apb_cmd_regs.sv
move_store.sv
dda_stepper.sv
quad_encoder.sv
motion_top.sv
tb_motion_properties.sv
tb_motion_top.sv

// File: Bender.yml
package:
  name: motion_ctrl

sources:
  - motion_pkg.sv
  - apb_regs_pkg.sv
  - apb_cmd_regs.sv
  - move_store.sv
  - dda_stepper.sv
  - quad_encoder.sv
  - motion_top.sv
  - target: test
    files:
      - tb_motion_properties.sv
      - tb_motion_top.sv
